// File: ifm_sparse_top.f
+incdir+rtl
rtl/ifm_pkg.sv
rtl/ifm_chunk_compressor.sv
rtl/ifm_chunk_bank.sv
rtl/ifm_chunk_pingpong.sv
rtl/ifm_sparse_reader.sv
rtl/ifm_sparse_top.sv
verification/ifm_sparse_tb.sv

// File: verification/ifm_sparse_tb.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_sparse_tb;

	localparam int NUM_CU      = `COMPUTE_UNIT_NUM;
	localparam int NUM_CHUNKS  = 5;
	localparam int NUM_SWEEPS  = 5;
	localparam int RAND_READS  = 48;
	localparam int MODE_DENSE  = 0;
	localparam int MODE_SPARSE = 1;
	localparam int MODE_ZERO   = 2;
	localparam int MODE_LAST   = 3;
	// Reset plus every beat and read cycle with drains plus margin
	localparam int TIMEOUT_CYCLES = 2 + NUM_CHUNKS * (`BEATS_PER_CHUNK + 2)
		+ NUM_SWEEPS * (`MEM_SIZE + 2) + RAND_READS + 2 + 50;

	logic                             clk_i;
	logic                             reset_i;
	logic                             dense_valid_i;
	ifm_pkg::pixel_t [`BUS_SIZE-1:0]  dense_data_i;
	logic [NUM_CU-1:0]                rd_req_i;
	ifm_pkg::dense_pos_t [NUM_CU-1:0] rd_pos_i;
	logic [NUM_CU-1:0]                rd_valid_o;
	ifm_pkg::pixel_t [NUM_CU-1:0]     rd_data_o;
	logic                             chunk_ready_o;

	// Dense bytes of the last completed chunk and of the one being sent
	ifm_pkg::pixel_t model_mem [`MEM_SIZE];
	ifm_pkg::pixel_t next_mem [`MEM_SIZE];
	// Expected read results one and two cycles old
	logic            pend1_vld [NUM_CU];
	ifm_pkg::pixel_t pend1_dat [NUM_CU];
	logic            pend2_vld [NUM_CU];
	ifm_pkg::pixel_t pend2_dat [NUM_CU];
	logic [31:0]     rng_state;
	int              cycle_cnt;
	int              chunks_done;

	ifm_sparse_top i_ifm_sparse_top (
		 .clk_i
		,.reset_i
		,.dense_valid_i
		,.dense_data_i
		,.rd_req_i
		,.rd_pos_i
		,.rd_valid_o
		,.rd_data_o
		,.chunk_ready_o
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	////////////////////
	// Checks
	////////////////////

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input ifm_pkg::pixel_t got,
		input ifm_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_with_fail();
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_with_fail();
		end
	endtask

	// Run limit
	always @(posedge clk_i) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
			stop_with_fail();
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Advance one cycle
	// Check reads issued two cycles back and drop all strobes
	task automatic tick();
		@(posedge clk_i);
		#2;
		for (int n = 0; n < NUM_CU; n++) begin
			check_strobe($sformatf("rd_valid_o[%0d]", n), rd_valid_o[n], pend2_vld[n]);
			if (pend2_vld[n]) begin
				check_pixel($sformatf("rd_data_o[%0d]", n), rd_data_o[n], pend2_dat[n]);
			end
			pend2_vld[n] = pend1_vld[n];
			pend2_dat[n] = pend1_dat[n];
			pend1_vld[n] = 1'b0;
		end
		dense_valid_i = 1'b0;
		rd_req_i      = '0;
	endtask

	task automatic issue_read(input int n, input ifm_pkg::dense_pos_t pos);
		rd_req_i[n]  = 1'b1;
		rd_pos_i[n]  = pos;
		pend1_vld[n] = 1'b1;
		// Dense byte as written, zeros included
		pend1_dat[n] = model_mem[pos];
	endtask

	task automatic drive_beat(input int b);
		dense_valid_i = 1'b1;
		for (int j = 0; j < `BUS_SIZE; j++) begin
			dense_data_i[j] = next_mem[b * `BUS_SIZE + j];
		end
	endtask

	task automatic make_chunk(input int mode);
		logic [31:0] r;
		for (int i = 0; i < `MEM_SIZE; i++) begin
			r = next_rand();
			case (mode)
				MODE_DENSE:  next_mem[i] = (r[7:0] == 8'h00) ? 8'h5a : r[7:0];
				MODE_SPARSE: next_mem[i] = r[8] ? 8'h00 : r[7:0];
				MODE_LAST:   next_mem[i] = (i == `MEM_SIZE - 1) ? (r[7:0] | 8'h01) : 8'h00;
				default:     next_mem[i] = 8'h00;
			endcase
		end
	endtask

	// Compressor stage and bank swap take two cycles after the last beat
	task automatic finish_chunk();
		tick();
		check_ready("chunk_ready_o", chunk_ready_o, chunks_done > 0);
		tick();
		check_ready("chunk_ready_o", chunk_ready_o, 1'b1);
		model_mem = next_mem;
		chunks_done++;
	endtask

	task automatic write_chunk();
		for (int b = 0; b < `BEATS_PER_CHUNK; b++) begin
			tick();
			drive_beat(b);
		end
		finish_chunk();
	endtask

	// Every position in turn
	// Unit 1 walks backwards
	task automatic read_sweep(input logic both, input int beats_alongside);
		for (int i = 0; i < `MEM_SIZE; i++) begin
			tick();
			if (i < beats_alongside) begin
				drive_beat(i);
			end
			issue_read(0, ifm_pkg::dense_pos_t'(i));
			if (both) begin
				issue_read(1, ifm_pkg::dense_pos_t'(`MEM_SIZE - 1 - i));
			end
		end
		// Drain the pipeline
		tick();
		tick();
	endtask

	task automatic read_random(input int count);
		for (int i = 0; i < count; i++) begin
			tick();
			for (int n = 0; n < NUM_CU; n++) begin
				issue_read(n, ifm_pkg::dense_pos_t'(next_rand()));
			end
		end
		tick();
		tick();
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset_state();
		check_ready("chunk_ready_o", chunk_ready_o, 1'b0);
		for (int n = 0; n < NUM_CU; n++) begin
			check_strobe($sformatf("rd_valid_o[%0d]", n), rd_valid_o[n], 1'b0);
		end
		tick();
	endtask

	task automatic test_dense_chunk();
		make_chunk(MODE_DENSE);
		write_chunk();
		read_sweep(1'b0, 0);
	endtask

	task automatic test_sparse_chunk();
		make_chunk(MODE_SPARSE);
		write_chunk();
		read_random(RAND_READS);
	endtask

	// Chunk B streams in while chunk A is read
	task automatic test_pingpong();
		make_chunk(MODE_SPARSE);
		read_sweep(1'b1, `BEATS_PER_CHUNK - 1);
		tick();
		drive_beat(`BEATS_PER_CHUNK - 1);
		finish_chunk();
		read_sweep(1'b1, 0);
	endtask

	task automatic test_edge_chunks();
		make_chunk(MODE_ZERO);
		write_chunk();
		read_sweep(1'b1, 0);
		make_chunk(MODE_LAST);
		write_chunk();
		read_sweep(1'b1, 0);
	endtask

	initial begin
		reset_i       = 1'b1;
		dense_valid_i = 1'b0;
		dense_data_i  = '0;
		rd_req_i      = '0;
		rd_pos_i      = '0;
		rng_state     = 32'h4c0d;
		cycle_cnt     = 0;
		chunks_done   = 0;
		for (int n = 0; n < NUM_CU; n++) begin
			pend1_vld[n] = 1'b0;
			pend1_dat[n] = 8'h00;
			pend2_vld[n] = 1'b0;
			pend2_dat[n] = 8'h00;
		end
		repeat (2) @(posedge clk_i);
		#2;
		reset_i = 1'b0;
		test_reset_state();
		test_dense_chunk();
		test_sparse_chunk();
		test_pingpong();
		test_edge_chunks();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: rtl/ifm_sparse_top.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_sparse_top (
	 input  logic                                        clk_i
	,input  logic                                        reset_i
	// Dense activation beats
	,input  logic                                        dense_valid_i
	,input  ifm_pkg::pixel_t [`BUS_SIZE-1:0]             dense_data_i
	// Compute unit read ports
	,input  logic [`COMPUTE_UNIT_NUM-1:0]                rd_req_i
	,input  ifm_pkg::dense_pos_t [`COMPUTE_UNIT_NUM-1:0] rd_pos_i
	,output logic [`COMPUTE_UNIT_NUM-1:0]                rd_valid_o
	,output ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_data_o
	,output logic                                        chunk_ready_o
);

	// Compressor to buffer
	logic                            wr_valid;
	ifm_pkg::beat_idx_t              wr_count;
	ifm_pkg::smap_word_t             wr_sparsemap;
	ifm_pkg::pixel_t [`BUS_SIZE-1:0] wr_nonzero_data;
	ifm_pkg::fill_cnt_t              wr_nonzero_num;

	// Reader to buffer lookups
	ifm_pkg::beat_idx_t [`COMPUTE_UNIT_NUM-1:0]  rd_beat;
	ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_addr;
	ifm_pkg::smap_word_t [`COMPUTE_UNIT_NUM-1:0] rd_sparsemap;
	ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_prefix;
	ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_bank_data;

	ifm_chunk_compressor u_compressor (
		 .clk_i
		,.reset_i
		,.dense_valid_i
		,.dense_data_i
		,.wr_valid_o        (wr_valid)
		,.wr_count_o        (wr_count)
		,.wr_sparsemap_o    (wr_sparsemap)
		,.wr_nonzero_data_o (wr_nonzero_data)
		,.wr_nonzero_num_o  (wr_nonzero_num)
	);

	ifm_chunk_pingpong u_pingpong (
		 .clk_i
		,.reset_i
		,.wr_valid_i        (wr_valid)
		,.wr_count_i        (wr_count)
		,.wr_sparsemap_i    (wr_sparsemap)
		,.wr_nonzero_data_i (wr_nonzero_data)
		,.wr_nonzero_num_i  (wr_nonzero_num)
		,.rd_beat_i         (rd_beat)
		,.rd_addr_i         (rd_addr)
		,.rd_sparsemap_o    (rd_sparsemap)
		,.rd_prefix_o       (rd_prefix)
		,.rd_data_o         (rd_bank_data)
		,.chunk_ready_o
	);

	ifm_sparse_reader u_reader (
		 .clk_i
		,.reset_i
		,.rd_req_i
		,.rd_pos_i
		,.rd_beat_o         (rd_beat)
		,.rd_addr_o         (rd_addr)
		,.rd_sparsemap_i    (rd_sparsemap)
		,.rd_prefix_i       (rd_prefix)
		,.rd_data_i         (rd_bank_data)
		,.rd_valid_o
		,.rd_data_o
	);

endmodule

// File: rtl/ifm_sparse_reader.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_sparse_reader (
	 input  logic                                        clk_i
	,input  logic                                        reset_i
	// Requests from the compute units
	,input  logic [`COMPUTE_UNIT_NUM-1:0]                rd_req_i
	,input  ifm_pkg::dense_pos_t [`COMPUTE_UNIT_NUM-1:0] rd_pos_i
	// Lookups into the chunk buffer
	,output ifm_pkg::beat_idx_t [`COMPUTE_UNIT_NUM-1:0]  rd_beat_o
	,output ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_addr_o
	,input  ifm_pkg::smap_word_t [`COMPUTE_UNIT_NUM-1:0] rd_sparsemap_i
	,input  ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_prefix_i
	,input  ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_data_i
	// Dense bytes back to the units
	,output logic [`COMPUTE_UNIT_NUM-1:0]                rd_valid_o
	,output ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_data_o
);

	localparam int OFF_W = $clog2(`BUS_SIZE);
	localparam int POS_W = $bits(ifm_pkg::dense_pos_t);

	for (genvar n = 0; n < `COMPUTE_UNIT_NUM; n++) begin : g_unit
		// Byte lane within the beat
		logic [OFF_W-1:0]   lane_c;
		// Nonzero bytes ahead of this lane
		ifm_pkg::fill_cnt_t below_c;
		ifm_pkg::fill_cnt_t addr_c;
		// Stage 1
		logic               s1_valid_q;
		logic               s1_bit_q;
		ifm_pkg::fill_cnt_t s1_addr_q;
		// Stage 2
		logic               s2_valid_q;
		ifm_pkg::pixel_t    s2_data_q;

		////////////////////
		// Stage 1 decode
		////////////////////

		assign lane_c       = rd_pos_i[n][OFF_W-1:0];
		assign rd_beat_o[n] = rd_pos_i[n][POS_W-1:OFF_W];

		// Popcount of sparsemap bits below the lane
		always_comb begin
			below_c = '0;
			for (int b = 0; b < `BUS_SIZE; b++) begin
				if ((b < lane_c) && rd_sparsemap_i[n][b]) begin
					below_c = below_c + 1'b1;
				end
			end
		end

		assign addr_c = rd_prefix_i[n] + below_c;

		////////////////////
		// Pipeline regs
		////////////////////

		always_ff @(posedge clk_i) begin
			if (reset_i) begin
				s1_valid_q <= 1'b0;
				s2_valid_q <= 1'b0;
			end else begin
				s1_valid_q <= rd_req_i[n];
				s2_valid_q <= s1_valid_q;
			end
		end

		always_ff @(posedge clk_i) begin
			if (rd_req_i[n]) begin
				s1_addr_q <= addr_c;
				s1_bit_q  <= rd_sparsemap_i[n][lane_c];
			end
			// Clear bit means a zero byte in dense form
			if (s1_valid_q) begin
				s2_data_q <= s1_bit_q ? rd_data_i[n] : 8'h00;
			end
		end

		// Stage 2 fetch from the packed store
		assign rd_addr_o[n]  = s1_addr_q;
		assign rd_valid_o[n] = s2_valid_q;
		assign rd_data_o[n]  = s2_data_q;

		// Prefix plus lane count stays inside the chunk
		a_addr_in_range: assert property (
			@(posedge clk_i) disable iff (reset_i)
			s1_valid_q |-> (s1_addr_q < `MEM_SIZE)
		);
	end

endmodule

// File: rtl/ifm_chunk_pingpong.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_chunk_pingpong (
	 input  logic                                        clk_i
	,input  logic                                        reset_i
	// Compressed beat from the producer
	,input  logic                                        wr_valid_i
	,input  ifm_pkg::beat_idx_t                          wr_count_i
	,input  ifm_pkg::smap_word_t                         wr_sparsemap_i
	,input  ifm_pkg::pixel_t [`BUS_SIZE-1:0]             wr_nonzero_data_i
	,input  ifm_pkg::fill_cnt_t                          wr_nonzero_num_i
	// Per unit lookups into the read bank
	,input  ifm_pkg::beat_idx_t [`COMPUTE_UNIT_NUM-1:0]  rd_beat_i
	,input  ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_addr_i
	,output ifm_pkg::smap_word_t [`COMPUTE_UNIT_NUM-1:0] rd_sparsemap_o
	,output ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_prefix_o
	,output ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_data_o
	// First chunk has landed
	,output logic                                        chunk_ready_o
);

	localparam int LAST_BEAT = `BEATS_PER_CHUNK - 1;

	// Bank being filled
	logic       wr_sel;
	// Bank being read
	logic       rd_sel_w;
	logic [1:0] wr_val_w;
	logic       chunk_done_w;

	// Lookup results of both banks
	ifm_pkg::smap_word_t [`COMPUTE_UNIT_NUM-1:0] bank_smap_w [2];
	ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  bank_prefix_w [2];
	ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     bank_data_w [2];

	////////////////////
	// Bank select
	////////////////////

	assign wr_val_w[0]  = wr_valid_i && !wr_sel;
	assign wr_val_w[1]  = wr_valid_i &&  wr_sel;
	assign rd_sel_w     = ~wr_sel;
	// Last beat of a chunk swaps the roles
	assign chunk_done_w = wr_valid_i && (wr_count_i == ifm_pkg::beat_idx_t'(LAST_BEAT));

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_sel        <= 1'b0;
			chunk_ready_o <= 1'b0;
		end else if (chunk_done_w) begin
			wr_sel        <= ~wr_sel;
			// Sticky until reset
			chunk_ready_o <= 1'b1;
		end
	end

	for (genvar b = 0; b < 2; b++) begin : g_bank
		ifm_chunk_bank u_bank (
			 .clk_i
			,.reset_i
			,.wr_valid_i        (wr_val_w[b])
			,.wr_count_i
			,.wr_sparsemap_i
			,.wr_nonzero_data_i
			,.wr_nonzero_num_i
			,.rd_beat_i
			,.rd_addr_i
			,.rd_sparsemap_o    (bank_smap_w[b])
			,.rd_prefix_o       (bank_prefix_w[b])
			,.rd_data_o         (bank_data_w[b])
		);
	end

	// Every unit sees the completed bank
	for (genvar n = 0; n < `COMPUTE_UNIT_NUM; n++) begin : g_rd_mux
		assign rd_sparsemap_o[n] = bank_smap_w[rd_sel_w][n];
		assign rd_prefix_o[n]    = bank_prefix_w[rd_sel_w][n];
		assign rd_data_o[n]      = bank_data_w[rd_sel_w][n];
	end

endmodule

// File: rtl/ifm_chunk_bank.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_chunk_bank (
	 input  logic                                        clk_i
	,input  logic                                        reset_i
	// Compressed beat to append
	,input  logic                                        wr_valid_i
	,input  ifm_pkg::beat_idx_t                          wr_count_i
	,input  ifm_pkg::smap_word_t                         wr_sparsemap_i
	,input  ifm_pkg::pixel_t [`BUS_SIZE-1:0]             wr_nonzero_data_i
	,input  ifm_pkg::fill_cnt_t                          wr_nonzero_num_i
	// One lookup port per compute unit
	,input  ifm_pkg::beat_idx_t [`COMPUTE_UNIT_NUM-1:0]  rd_beat_i
	,input  ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_addr_i
	,output ifm_pkg::smap_word_t [`COMPUTE_UNIT_NUM-1:0] rd_sparsemap_o
	,output ifm_pkg::fill_cnt_t [`COMPUTE_UNIT_NUM-1:0]  rd_prefix_o
	,output ifm_pkg::pixel_t [`COMPUTE_UNIT_NUM-1:0]     rd_data_o
);

	// Packed nonzero bytes of the chunk
	ifm_pkg::pixel_t     data_q [`MEM_SIZE];
	// Per beat sparsemap word and its packed start
	ifm_pkg::smap_word_t smap_q [`BEATS_PER_CHUNK];
	ifm_pkg::fill_cnt_t  prefix_q [`BEATS_PER_CHUNK];

	// Next free packed slot
	ifm_pkg::fill_cnt_t fill_q;
	// Where the current beat lands
	ifm_pkg::fill_cnt_t base_c;

	////////////////////
	// Write side
	////////////////////

	// Beat zero starts a fresh chunk
	assign base_c = (wr_count_i == '0) ? '0 : fill_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			fill_q <= '0;
		end else if (wr_valid_i) begin
			fill_q <= base_c + wr_nonzero_num_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			smap_q[wr_count_i]   <= wr_sparsemap_i;
			// Prefix is the fill level before this append
			prefix_q[wr_count_i] <= base_c;
			// Only the popcount worth of bytes is real data
			for (int j = 0; j < `BUS_SIZE; j++) begin
				if (j < wr_nonzero_num_i) begin
					data_q[ifm_pkg::dense_pos_t'(base_c + j)] <= wr_nonzero_data_i[j];
				end
			end
		end
	end

	////////////////////
	// Read side
	////////////////////

	// Plain combinational lookups
	for (genvar n = 0; n < `COMPUTE_UNIT_NUM; n++) begin : g_rd
		assign rd_sparsemap_o[n] = smap_q[rd_beat_i[n]];
		assign rd_prefix_o[n]    = prefix_q[rd_beat_i[n]];
		assign rd_data_o[n]      = data_q[ifm_pkg::dense_pos_t'(rd_addr_i[n])];
	end

	// Whole chunk of packed bytes must fit the store
	a_no_overflow: assert property (
		@(posedge clk_i) disable iff (reset_i)
		wr_valid_i |-> (base_c + wr_nonzero_num_i <= `MEM_SIZE)
	);

endmodule

// File: rtl/ifm_chunk_compressor.sv
`timescale 1ns/10ps
`include "ifm_defs.svh"

module ifm_chunk_compressor (
	 input  logic                            clk_i
	,input  logic                            reset_i
	// Dense beat from the fetch side
	,input  logic                            dense_valid_i
	,input  ifm_pkg::pixel_t [`BUS_SIZE-1:0] dense_data_i
	// Compressed beat toward the ping-pong buffer
	,output logic                            wr_valid_o
	,output ifm_pkg::beat_idx_t              wr_count_o
	,output ifm_pkg::smap_word_t             wr_sparsemap_o
	,output ifm_pkg::pixel_t [`BUS_SIZE-1:0] wr_nonzero_data_o
	,output ifm_pkg::fill_cnt_t              wr_nonzero_num_o
);

	localparam int LAST_BEAT = `BEATS_PER_CHUNK - 1;

	// Slot of the next dense beat within the chunk
	ifm_pkg::beat_idx_t beat_cnt_q;

	// Compressed form of the incoming beat
	ifm_pkg::smap_word_t             smap_c;
	ifm_pkg::pixel_t [`BUS_SIZE-1:0] nz_data_c;
	ifm_pkg::fill_cnt_t              nz_num_c;

	////////////////////
	// Compaction
	////////////////////

	always_comb begin
		smap_c    = '0;
		nz_data_c = '0;
		nz_num_c  = '0;
		// Low lanes first so packed order follows dense order
		for (int i = 0; i < `BUS_SIZE; i++) begin
			smap_c[i] = (dense_data_i[i] != 8'h00);
			if (smap_c[i]) begin
				// Next free packed slot is the running count
				nz_data_c[nz_num_c] = dense_data_i[i];
				nz_num_c            = nz_num_c + 1'b1;
			end
		end
	end

	////////////////////
	// Output stage
	////////////////////

	// Strobe and beat counter
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_valid_o <= 1'b0;
			beat_cnt_q <= '0;
		end else begin
			wr_valid_o <= dense_valid_i;
			if (dense_valid_i) begin
				// Wrap at the chunk boundary
				if (beat_cnt_q == ifm_pkg::beat_idx_t'(LAST_BEAT)) begin
					beat_cnt_q <= '0;
				end else begin
					beat_cnt_q <= beat_cnt_q + 1'b1;
				end
			end
		end
	end

	// Compressed payload captured with each dense beat
	always_ff @(posedge clk_i) begin
		if (dense_valid_i) begin
			wr_count_o        <= beat_cnt_q;
			wr_sparsemap_o    <= smap_c;
			wr_nonzero_data_o <= nz_data_c;
			wr_nonzero_num_o  <= nz_num_c;
		end
	end

	// Bank append length must match the sparsemap it stores
	a_num_matches_smap: assert property (
		@(posedge clk_i) disable iff (reset_i)
		wr_valid_o |-> (wr_nonzero_num_o == $countones(wr_sparsemap_o))
	);

endmodule

// File: rtl/ifm_pkg.sv
`include "ifm_defs.svh"

package ifm_pkg;

	////////////////////
	// Data types
	////////////////////

	// One activation byte
	typedef logic [7:0] pixel_t;

	// One bit per byte lane of a beat
	// Bit set where that byte is nonzero
	typedef logic [`BUS_SIZE-1:0] smap_word_t;

	// Beat slot inside a chunk
	typedef logic [$clog2(`BEATS_PER_CHUNK)-1:0] beat_idx_t;

	////////////////////
	// Address types
	////////////////////

	// Packed byte count or packed address
	// Extra top bit so a full chunk count still fits
	typedef logic [$clog2(`MEM_SIZE):0] fill_cnt_t;

	// Dense byte position in a chunk
	// High bits select the beat and low bits the byte lane
	typedef logic [$clog2(`MEM_SIZE)-1:0] dense_pos_t;

endpackage

// File: rtl/ifm_defs.svh
`ifndef IFM_DEFS_SVH
`define IFM_DEFS_SVH

////////////////////
// Chunk geometry
////////////////////

// Bytes held by one chunk
`define MEM_SIZE 32

// Bytes per dense beat
// Also the bit width of one sparsemap word
`define BUS_SIZE 8

// Dense beats that fill one chunk
`define BEATS_PER_CHUNK (`MEM_SIZE / `BUS_SIZE)

////////////////////
// Read side
////////////////////

// Compute units sharing the chunk buffer
// Each one gets its own read port
`define COMPUTE_UNIT_NUM 2

`endif
